//--- common/floppy_pkg.sv
`default_nettype none

package floppy_pkg;

	////////////////////////////////////////////////////////////
	// buses
	////////////////////////////////////////////////////////////

	// workhorse memory-mapped bus, one request per cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
		logic        rd;
	} wh_bus_t;

	// one access to the sector buffer
	typedef struct packed {
		logic [9:0] addr;
		logic [7:0] data;
		logic       we;
		logic       en;
	} buf_req_t;

	////////////////////////////////////////////////////////////
	// WD1793 status byte
	////////////////////////////////////////////////////////////

	// type I commands (restore, seek, step)
	typedef struct packed {
		logic not_ready;
		logic write_prot;
		logic head_loaded;
		logic seek_err;
		logic crc_err;
		logic track0;
		logic index;
		logic busy;
	} wd_stat_type1_t;

	// type II commands (read/write sector)
	typedef struct packed {
		logic not_ready;
		logic write_fault;
		logic rec_type;
		logic rnf;
		logic crc_err;
		logic lost_data;
		logic drq;
		logic busy;
	} wd_stat_type2_t;

	// busy is bit 0 in both views
	typedef union packed {
		wd_stat_type1_t t1;
		wd_stat_type2_t t2;
	} wd_status_u;

	////////////////////////////////////////////////////////////
	// address map
	////////////////////////////////////////////////////////////

	// offsets in the workhorse I/O window
	localparam logic [7:0] PORT_MMCA        = 8'd0;
	localparam logic [7:0] PORT_SPDR        = 8'd1;
	localparam logic [7:0] PORT_SPSR        = 8'd2;
	localparam logic [7:0] PORT_CPU_REQUEST = 8'd9;
	localparam logic [7:0] PORT_CPU_STATUS  = 8'd10;
	localparam logic [7:0] PORT_TRACK       = 8'd11;
	localparam logic [7:0] PORT_SECTOR      = 8'd12;
	localparam logic [7:0] PORT_DMA_MSB     = 8'd14;
	localparam logic [7:0] PORT_DMA_LSB     = 8'd15;

	// host register select
	localparam logic [2:0] WD_DATA     = 3'd0;
	localparam logic [2:0] WD_SECTOR   = 3'd1;
	localparam logic [2:0] WD_TRACK    = 3'd2;
	localparam logic [2:0] WD_CMD_STAT = 3'd3;

	localparam logic [15:0] BUF_BASE    = 16'h0200;
	localparam int          BUF_BYTES   = 1024;
	localparam int          BLOCK_BYTES = 256;

endpackage

`default_nettype wire

//--- logic/sector_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module sector_buffer (
	input  wire                   clk,
	input  floppy_pkg::buf_req_t  host_req,
	input  floppy_pkg::buf_req_t  dma_req,
	input  floppy_pkg::buf_req_t  wh_req,
	output logic [7:0]            rdata
);
	import floppy_pkg::*;

	logic [7:0] mem [0:BUF_BYTES-1];
	buf_req_t   sel;

	// fixed priority: host, then dma, then workhorse
	// the losing request is dropped for this cycle
	always_comb begin
		if (host_req.en) begin
			sel = host_req;
		end else if (dma_req.en) begin
			sel = dma_req;
		end else begin
			sel = wh_req;
		end
	end

	// single port, read returns the old byte on a write
	always_ff @(posedge clk) begin
		if (sel.en) begin
			if (sel.we) begin
				mem[sel.addr] <= sel.data;
			end
			rdata <= mem[sel.addr];
		end
	end

endmodule

`default_nettype wire

//--- logic/io_port_regs.sv
`timescale 1ns/1ns
`default_nettype none

module io_port_regs #(
	parameter logic [15:0] IOBASE = 16'hE000
) (
	input  wire                   clk,
	input  wire                   reset_n,
	input  floppy_pkg::wh_bus_t   wh_bus,
	output logic [7:0]            wh_rdata,
	output floppy_pkg::buf_req_t  buf_req,
	input  wire [7:0]             buf_rdata,
	input  wire [7:0]             cpu_request,
	input  wire [7:0]             track,
	input  wire [7:0]             sector,
	output logic                  cpu_status_wr,
	output logic [7:0]            cpu_status,
	output logic                  spi_wr,
	output logic [7:0]            spi_wdata,
	input  wire [7:0]             spi_rdata,
	input  wire                   spi_dsr,
	input  wire                   dma_busy,
	output logic                  dma_start,
	output logic [9:0]            dma_addr,
	output logic [3:0]            dma_blocks,
	output logic                  sd_cs
);
	import floppy_pkg::*;

	logic        in_buf;
	logic        in_io;
	logic [7:0]  port;
	logic        io_wr;
	logic [15:0] buf_off;
	logic [15:0] dma_off;
	logic [7:0]  dma_msb;
	logic [7:0]  dma_lsb;
	logic [7:0]  port_mux;
	logic [7:0]  port_q;
	logic        buf_sel_q;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	assign in_buf = (wh_bus.addr >= BUF_BASE) && (wh_bus.addr < BUF_BASE + BUF_BYTES);
	assign in_io  = (wh_bus.addr[15:8] == IOBASE[15:8]);
	assign port   = wh_bus.addr[7:0];
	assign io_wr  = in_io && wh_bus.wr;

	assign buf_off      = wh_bus.addr - BUF_BASE;
	assign buf_req.addr = buf_off[9:0];
	assign buf_req.data = wh_bus.wdata;
	assign buf_req.we   = in_buf && wh_bus.wr;
	assign buf_req.en   = in_buf && (wh_bus.wr || wh_bus.rd);

	////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////

	// strobes to the host regs, spi and dma
	assign cpu_status_wr = io_wr && (port == PORT_CPU_STATUS);
	assign cpu_status    = wh_bus.wdata;
	assign spi_wr        = io_wr && (port == PORT_SPDR);
	assign spi_wdata     = wh_bus.wdata;
	assign dma_start     = io_wr && (port == PORT_SPSR) && (wh_bus.wdata[7:4] != 4'd0);
	assign dma_blocks    = wh_bus.wdata[7:4];

	// dma target given as a workhorse address
	assign dma_off  = {dma_msb, dma_lsb} - BUF_BASE;
	assign dma_addr = dma_off[9:0];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sd_cs   <= 1'b1;
			dma_msb <= 8'h00;
			dma_lsb <= 8'h00;
		end else if (io_wr) begin
			case (port)
				PORT_MMCA:    sd_cs   <= wh_bus.wdata[0];
				PORT_DMA_MSB: dma_msb <= wh_bus.wdata;
				PORT_DMA_LSB: dma_lsb <= wh_bus.wdata;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////

	always_comb begin
		port_mux = 8'hFF;
		if (in_io) begin
			case (port)
				PORT_MMCA:        port_mux = {7'd0, sd_cs};
				PORT_SPDR:        port_mux = spi_rdata;
				// bit 0 low when a byte is ready
				PORT_SPSR:        port_mux = {6'd0, dma_busy, ~spi_dsr};
				PORT_CPU_REQUEST: port_mux = cpu_request;
				PORT_TRACK:       port_mux = track;
				PORT_SECTOR:      port_mux = sector;
				PORT_DMA_MSB:     port_mux = dma_msb;
				PORT_DMA_LSB:     port_mux = dma_lsb;
				default:          port_mux = 8'hFF;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wh_bus.rd) begin
			port_q <= port_mux;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			buf_sel_q <= 1'b0;
		end else if (wh_bus.rd) begin
			buf_sel_q <= in_buf;
		end
	end

	// buffer data arrives registered, same cycle as port_q
	assign wh_rdata = buf_sel_q ? buf_rdata : port_q;

endmodule

`default_nettype wire

//--- logic/spi_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master #(
	parameter int SPI_DIV = 4
) (
	input  wire        clk,
	input  wire        reset_n,
	input  wire        wr_a,
	input  wire [7:0]  wdata_a,
	input  wire        wr_b,
	input  wire [7:0]  wdata_b,
	input  wire        sel_b,
	output logic       sck,
	output logic       mosi,
	input  wire        miso,
	output logic [7:0] rdata,
	output logic       dsr
);
	localparam int DIV_W = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;

	logic             wr;
	logic [7:0]       wdata;
	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	logic [3:0]       edge_cnt;
	logic [7:0]       shreg;
	logic             miso_q;

	// two writers, the selected one owns the data
	assign wr    = wr_a | wr_b;
	assign wdata = sel_b ? wdata_b : wdata_a;

	// mode 0: sample on rising sck, shift on falling
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy     <= 1'b0;
			sck      <= 1'b0;
			dsr      <= 1'b0;
			div_cnt  <= '0;
			edge_cnt <= 4'd0;
			shreg    <= 8'hFF;
			miso_q   <= 1'b1;
		end else if (wr) begin
			busy     <= 1'b1;
			sck      <= 1'b0;
			dsr      <= 1'b0;
			div_cnt  <= '0;
			edge_cnt <= 4'd0;
			shreg    <= wdata;
		end else if (busy) begin
			if (div_cnt == DIV_W'(SPI_DIV - 1)) begin
				div_cnt  <= '0;
				sck      <= ~sck;
				edge_cnt <= edge_cnt + 4'd1;
				if (!sck) begin
					miso_q <= miso;
				end else begin
					shreg <= {shreg[6:0], miso_q};
					// 16th edge ends the byte
					if (edge_cnt == 4'd15) begin
						busy <= 1'b0;
						dsr  <= 1'b1;
					end
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	assign mosi  = busy ? shreg[7] : 1'b1;
	assign rdata = shreg;

endmodule

`default_nettype wire

//--- logic/sector_dma.sv
`timescale 1ns/1ns
`default_nettype none

module sector_dma (
	input  wire                   clk,
	input  wire                   reset_n,
	input  wire                   start,
	input  wire [9:0]             addr,
	input  wire [3:0]             blocks,
	output logic                  spi_wr,
	output logic [7:0]            spi_wdata,
	input  wire [7:0]             spi_rdata,
	input  wire                   spi_dsr,
	output floppy_pkg::buf_req_t  buf_req,
	output logic                  busy
);
	import floppy_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_SEND,
		S_WAIT
	} state_t;

	state_t      state;
	logic [9:0]  ptr;
	logic [11:0] remaining;
	logic        store;

	assign busy  = (state != S_IDLE);
	assign store = (state == S_WAIT) && spi_dsr;

	// clock out dummy bytes, card answers on miso
	assign spi_wr    = (state == S_SEND);
	assign spi_wdata = 8'hFF;

	assign buf_req.addr = ptr;
	assign buf_req.data = spi_rdata;
	assign buf_req.we   = store;
	assign buf_req.en   = store;

	////////////////////////////////////////////////////////////
	// byte loop
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state     <= S_IDLE;
			ptr       <= 10'd0;
			remaining <= 12'd0;
		end else begin
			case (state)
				S_IDLE: begin
					// start while busy never reaches here
					if (start && (blocks != 4'd0)) begin
						ptr       <= addr;
						remaining <= 12'(blocks * BLOCK_BYTES);
						state     <= S_SEND;
					end
				end
				S_SEND: begin
					state <= S_WAIT;
				end
				S_WAIT: begin
					if (spi_dsr) begin
						// ptr wraps inside the 1k buffer
						ptr       <= ptr + 10'd1;
						remaining <= remaining - 12'd1;
						if (remaining == 12'd1) begin
							state <= S_IDLE;
						end else begin
							state <= S_SEND;
						end
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- wd1793/wd_host_regs.sv
`timescale 1ns/1ns
`default_nettype none

module wd_host_regs (
	input  wire                   clk,
	input  wire                   reset_n,
	input  wire [2:0]             host_addr,
	input  wire [7:0]             host_wdata,
	input  wire                   host_rd,
	input  wire                   host_wr,
	output logic [7:0]            host_rdata,
	output floppy_pkg::buf_req_t  buf_req,
	input  wire [7:0]             buf_rdata,
	output logic [7:0]            cpu_request,
	output logic [7:0]            track,
	output logic [7:0]            sector,
	input  wire                   cpu_status_wr,
	input  wire [7:0]             cpu_status
);
	import floppy_pkg::*;

	logic       data_acc;
	logic       cmd_wr;
	logic [9:0] ptr;
	logic       pending;
	wd_status_u status_q;
	wd_status_u status_host;
	logic [7:0] reg_mux;
	logic [7:0] rd_q;
	logic       rd_buf_q;

	assign data_acc = (host_rd || host_wr) && (host_addr == WD_DATA);
	assign cmd_wr   = host_wr && (host_addr == WD_CMD_STAT);

	// data register goes straight to the buffer
	assign buf_req.addr = ptr;
	assign buf_req.data = host_wdata;
	assign buf_req.we   = host_wr && (host_addr == WD_DATA);
	assign buf_req.en   = data_acc;

	////////////////////////////////////////////////////////////
	// registers and workhorse exchange
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			track       <= 8'h00;
			sector      <= 8'h00;
			cpu_request <= 8'h00;
			pending     <= 1'b0;
			status_q    <= '0;
			ptr         <= 10'd0;
		end else begin
			if (host_wr && (host_addr == WD_TRACK)) begin
				track <= host_wdata;
			end
			if (host_wr && (host_addr == WD_SECTOR)) begin
				sector <= host_wdata;
			end

			// workhorse answer closes the request
			if (cpu_status_wr) begin
				cpu_request <= 8'h00;
				pending     <= 1'b0;
				status_q    <= wd_status_u'(cpu_status);
			end

			// a new command wins over a status write in the same cycle
			if (cmd_wr) begin
				cpu_request <= host_wdata;
				pending     <= 1'b1;
				ptr         <= 10'd0;
			end else if (data_acc) begin
				ptr <= ptr + 10'd1;
			end
		end
	end

	// busy held while the workhorse has not answered
	always_comb begin
		status_host         = status_q;
		status_host.t1.busy = status_q.t1.busy | pending;
	end

	////////////////////////////////////////////////////////////
	// host read path
	////////////////////////////////////////////////////////////

	always_comb begin
		case (host_addr)
			WD_SECTOR:   reg_mux = sector;
			WD_TRACK:    reg_mux = track;
			WD_CMD_STAT: reg_mux = status_host;
			default:     reg_mux = 8'hFF;
		endcase
	end

	always_ff @(posedge clk) begin
		if (host_rd) begin
			rd_q <= reg_mux;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rd_buf_q <= 1'b0;
		end else if (host_rd) begin
			rd_buf_q <= (host_addr == WD_DATA);
		end
	end

	// data reads come back from the buffer a cycle later
	assign host_rdata = rd_buf_q ? buf_rdata : rd_q;

endmodule

`default_nettype wire

//--- logic/floppy_emu.sv
`timescale 1ns/1ns
`default_nettype none

module floppy_emu #(
	parameter logic [15:0] IOBASE  = 16'hE000,
	parameter int          SPI_DIV = 4
) (
	input  wire                  clk,
	input  wire                  reset_n,
	// host register window
	input  wire [2:0]            host_addr,
	input  wire [7:0]            host_wdata,
	input  wire                  host_rd,
	input  wire                  host_wr,
	output logic [7:0]           host_rdata,
	// workhorse bus
	input  floppy_pkg::wh_bus_t  wh_bus,
	output logic [7:0]           wh_rdata,
	// sd card
	output logic                 sd_cs,
	output logic                 sd_sck,
	output logic                 sd_mosi,
	input  wire                  sd_miso
);
	import floppy_pkg::*;

	buf_req_t   host_buf_req;
	buf_req_t   dma_buf_req;
	buf_req_t   wh_buf_req;
	logic [7:0] buf_rdata;

	logic [7:0] cpu_request;
	logic [7:0] track;
	logic [7:0] sector;
	logic       cpu_status_wr;
	logic [7:0] cpu_status;

	logic       io_spi_wr;
	logic [7:0] io_spi_wdata;
	logic       dma_spi_wr;
	logic [7:0] dma_spi_wdata;
	logic [7:0] spi_rdata;
	logic       spi_dsr;

	logic       dma_busy;
	logic       dma_start;
	logic [9:0] dma_addr;
	logic [3:0] dma_blocks;

	wd_host_regs u_wd_host_regs (
		.clk           (clk),
		.reset_n       (reset_n),
		.host_addr     (host_addr),
		.host_wdata    (host_wdata),
		.host_rd       (host_rd),
		.host_wr       (host_wr),
		.host_rdata    (host_rdata),
		.buf_req       (host_buf_req),
		.buf_rdata     (buf_rdata),
		.cpu_request   (cpu_request),
		.track         (track),
		.sector        (sector),
		.cpu_status_wr (cpu_status_wr),
		.cpu_status    (cpu_status)
	);

	sector_buffer u_sector_buffer (
		.clk     (clk),
		.host_req(host_buf_req),
		.dma_req (dma_buf_req),
		.wh_req  (wh_buf_req),
		.rdata   (buf_rdata)
	);

	io_port_regs #(
		.IOBASE(IOBASE)
	) u_io_port_regs (
		.clk           (clk),
		.reset_n       (reset_n),
		.wh_bus        (wh_bus),
		.wh_rdata      (wh_rdata),
		.buf_req       (wh_buf_req),
		.buf_rdata     (buf_rdata),
		.cpu_request   (cpu_request),
		.track         (track),
		.sector        (sector),
		.cpu_status_wr (cpu_status_wr),
		.cpu_status    (cpu_status),
		.spi_wr        (io_spi_wr),
		.spi_wdata     (io_spi_wdata),
		.spi_rdata     (spi_rdata),
		.spi_dsr       (spi_dsr),
		.dma_busy      (dma_busy),
		.dma_start     (dma_start),
		.dma_addr      (dma_addr),
		.dma_blocks    (dma_blocks),
		.sd_cs         (sd_cs)
	);

	// workhorse is source a, dma takes over while busy
	spi_master #(
		.SPI_DIV(SPI_DIV)
	) u_spi_master (
		.clk     (clk),
		.reset_n (reset_n),
		.wr_a    (io_spi_wr),
		.wdata_a (io_spi_wdata),
		.wr_b    (dma_spi_wr),
		.wdata_b (dma_spi_wdata),
		.sel_b   (dma_busy),
		.sck     (sd_sck),
		.mosi    (sd_mosi),
		.miso    (sd_miso),
		.rdata   (spi_rdata),
		.dsr     (spi_dsr)
	);

	sector_dma u_sector_dma (
		.clk       (clk),
		.reset_n   (reset_n),
		.start     (dma_start),
		.addr      (dma_addr),
		.blocks    (dma_blocks),
		.spi_wr    (dma_spi_wr),
		.spi_wdata (dma_spi_wdata),
		.spi_rdata (spi_rdata),
		.spi_dsr   (spi_dsr),
		.buf_req   (dma_buf_req),
		.busy      (dma_busy)
	);

endmodule

`default_nettype wire

//--- sim/floppy_emu_props.sv
`timescale 1ns/1ns
`default_nettype none

module floppy_emu_props #(
	parameter int SPI_DIV = 4
) (
	input wire clk,
	input wire reset_n,
	input wire sd_sck,
	input wire spi_busy,
	input wire spi_dsr,
	input wire dma_busy,
	input wire dma_buf_we
);

	// sck parks low between bytes
	a_sck_idle_low: assert property (@(posedge clk) disable iff (!reset_n)
		!spi_busy |-> !sd_sck)
		else $error("sd_sck high while the spi master is idle");

	// dma only writes the buffer during a transfer
	a_dma_we_busy: assert property (@(posedge clk) disable iff (!reset_n)
		dma_buf_we |-> dma_busy)
		else $error("dma buffer write outside a dma transfer");

	// one byte is 16 sck half periods from the write to dsr
	a_spi_byte_time: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(spi_busy) |-> ##(16 * SPI_DIV) $rose(spi_dsr))
		else $error("spi dsr not raised 16 sck half periods after the write");

endmodule

bind floppy_emu floppy_emu_props #(
	.SPI_DIV(SPI_DIV)
) u_floppy_emu_props (
	.clk        (clk),
	.reset_n    (reset_n),
	.sd_sck     (sd_sck),
	.spi_busy   (u_spi_master.busy),
	.spi_dsr    (spi_dsr),
	.dma_busy   (dma_busy),
	.dma_buf_we (dma_buf_req.we)
);

`default_nettype wire

//--- sim/floppy_emu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module floppy_emu_tb;
	import floppy_pkg::*;

	localparam int          CLK_PERIOD = 8;
	localparam int          SPI_DIV    = 4;
	localparam logic [15:0] IOBASE     = 16'hE000;
	// two dma blocks at full spi speed, plus the register tests
	localparam int DMA_CYCLES = 2 * BLOCK_BYTES * (16 * SPI_DIV + 4);
	localparam int TIMEOUT_NS = (2 * DMA_CYCLES + 20000) * CLK_PERIOD;
	localparam int POLL_LIMIT = DMA_CYCLES;

	logic       clk;
	logic       reset_n;
	logic [2:0] host_addr;
	logic [7:0] host_wdata;
	logic       host_rd;
	logic       host_wr;
	logic [7:0] host_rdata;
	wh_bus_t    wh_bus;
	logic [7:0] wh_rdata;
	logic       sd_cs;
	logic       sd_sck;
	logic       sd_mosi;
	logic       sd_miso;

	int check_count;
	int err_count;

	// sd card model
	logic [31:0] card_state;
	logic [7:0]  card_byte;
	logic [7:0]  mosi_shift;
	logic [7:0]  mosi_byte;
	int          bit_cnt;
	// expected card sequence, same seed as the model
	logic [31:0] exp_state;

	floppy_emu #(
		.IOBASE (IOBASE),
		.SPI_DIV(SPI_DIV)
	) u_floppy_emu (
		.clk        (clk),
		.reset_n    (reset_n),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rd    (host_rd),
		.host_wr    (host_wr),
		.host_rdata (host_rdata),
		.wh_bus     (wh_bus),
		.wh_rdata   (wh_rdata),
		.sd_cs      (sd_cs),
		.sd_sck     (sd_sck),
		.sd_mosi    (sd_mosi),
		.sd_miso    (sd_miso)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [15:0] io_addr(input logic [7:0] port);
		return IOBASE | {8'h00, port};
	endfunction

	// touches every address bit
	function automatic logic [7:0] fill_byte(input logic [9:0] a);
		return a[7:0] ^ {a[9:8], 6'h2B};
	endfunction

	task automatic card_load_next();
		card_state = lcg_next(card_state);
		card_byte  = card_state[23:16];
		bit_cnt    = 0;
		sd_miso    = card_byte[7];
	endtask

	// mode 0 slave, sample on rising sck, next bit on falling sck
	always @(sd_sck) begin
		if (sd_sck) begin
			mosi_shift = {mosi_shift[6:0], sd_mosi};
			bit_cnt    = bit_cnt + 1;
			if (bit_cnt == 8) begin
				mosi_byte = mosi_shift;
			end
		end else if (bit_cnt == 8) begin
			card_load_next();
		end else begin
			sd_miso = card_byte[7 - bit_cnt];
		end
	end

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] want);
		check_count = check_count + 1;
		if (got !== want) begin
			err_count = err_count + 1;
			$display("ERR %s got %02h expected %02h", name, got, want);
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		$display("%-24s %s", name, (err_count == errs_before) ? "ok" : "mismatches");
	endtask

	task automatic host_write(input logic [2:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		host_addr  = addr;
		host_wdata = data;
		host_wr    = 1'b1;
		@(posedge clk);
		#1;
		host_wr = 1'b0;
	endtask

	task automatic host_read(input logic [2:0] addr, output logic [7:0] data);
		@(posedge clk);
		#1;
		host_addr = addr;
		host_rd   = 1'b1;
		@(posedge clk);
		#1;
		host_rd = 1'b0;
		data    = host_rdata;
	endtask

	task automatic wh_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		wh_bus.addr  = addr;
		wh_bus.wdata = data;
		wh_bus.wr    = 1'b1;
		@(posedge clk);
		#1;
		wh_bus.wr = 1'b0;
	endtask

	task automatic wh_read(input logic [15:0] addr, output logic [7:0] data);
		@(posedge clk);
		#1;
		wh_bus.addr = addr;
		wh_bus.rd   = 1'b1;
		@(posedge clk);
		#1;
		wh_bus.rd = 1'b0;
		data      = wh_rdata;
	endtask

	task automatic poll_spsr_clear(input int bit_idx, output bit done);
		logic [7:0] val;
		int         polls;
		done  = 1'b0;
		polls = 0;
		while (!done && polls < POLL_LIMIT) begin
			wh_read(io_addr(PORT_SPSR), val);
			done  = !val[bit_idx];
			polls = polls + 1;
		end
		if (!done) begin
			err_count = err_count + 1;
			$display("PORT_SPSR bit %0d still set after %0d polls", bit_idx, polls);
		end
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic reset_values();
		int         errs;
		logic [7:0] val;
		errs = err_count;
		wh_read(io_addr(PORT_CPU_REQUEST), val);
		check_value("cpu_request", val, 8'h00);
		host_read(WD_CMD_STAT, val);
		check_value("host status", val, 8'h00);
		check_value("sd_cs", {7'd0, sd_cs}, 8'h01);
		wh_read(io_addr(PORT_MMCA), val);
		check_value("PORT_MMCA", val, 8'h01);
		// dma idle, no byte ready
		wh_read(io_addr(PORT_SPSR), val);
		check_value("PORT_SPSR", val, 8'h01);
		finish_test("reset", errs);
	endtask

	task automatic command_exchange();
		int         errs;
		logic [7:0] val;
		errs = err_count;
		host_write(WD_CMD_STAT, 8'h88);
		wh_read(io_addr(PORT_CPU_REQUEST), val);
		check_value("cpu_request", val, 8'h88);
		host_read(WD_CMD_STAT, val);
		check_value("host status", val, 8'h01);
		wh_write(io_addr(PORT_CPU_STATUS), 8'h02);
		wh_read(io_addr(PORT_CPU_REQUEST), val);
		check_value("cpu_request", val, 8'h00);
		host_read(WD_CMD_STAT, val);
		check_value("host status", val, 8'h02);
		finish_test("command exchange", errs);
	endtask

	task automatic data_path();
		int         errs;
		logic [7:0] val;
		errs = err_count;
		// host to workhorse
		host_write(WD_CMD_STAT, 8'hA8);
		for (int i = 0; i < 8; i++) begin
			host_write(WD_DATA, 8'h30 + 8'(i * 7));
		end
		for (int i = 0; i < 8; i++) begin
			wh_read(BUF_BASE + 16'(i), val);
			check_value($sformatf("wh_rdata[%0d]", i), val, 8'h30 + 8'(i * 7));
		end
		// workhorse to host
		for (int i = 0; i < 8; i++) begin
			wh_write(BUF_BASE + 16'(i), 8'hC3 ^ 8'(i * 5));
		end
		host_write(WD_CMD_STAT, 8'h88);
		for (int i = 0; i < 8; i++) begin
			host_read(WD_DATA, val);
			check_value($sformatf("host_rdata[%0d]", i), val, 8'hC3 ^ 8'(i * 5));
		end
		wh_write(io_addr(PORT_CPU_STATUS), 8'h00);
		finish_test("data path", errs);
	endtask

	task automatic spi_port_byte();
		int         errs;
		logic [7:0] val;
		bit         done;
		errs = err_count;
		wh_write(io_addr(PORT_MMCA), 8'h00);
		check_value("sd_cs", {7'd0, sd_cs}, 8'h00);
		wh_write(io_addr(PORT_SPDR), 8'hA5);
		poll_spsr_clear(0, done);
		check_value("sd_mosi byte", mosi_byte, 8'hA5);
		exp_state = lcg_next(exp_state);
		wh_read(io_addr(PORT_SPDR), val);
		check_value("PORT_SPDR", val, exp_state[23:16]);
		finish_test("spi port", errs);
	endtask

	task automatic dma_two_blocks();
		int         errs;
		logic [7:0] val;
		logic [7:0] want;
		bit         done;
		errs = err_count;
		for (int i = 0; i < BUF_BYTES; i++) begin
			wh_write(BUF_BASE + 16'(i), fill_byte(10'(i)));
		end
		// target BUF_BASE + 256
		wh_write(io_addr(PORT_DMA_MSB), 8'h03);
		wh_write(io_addr(PORT_DMA_LSB), 8'h00);
		wh_write(io_addr(PORT_SPSR), 8'h20);
		poll_spsr_clear(1, done);
		for (int i = 0; i < BUF_BYTES; i++) begin
			wh_read(BUF_BASE + 16'(i), val);
			if (i >= BLOCK_BYTES && i < 3 * BLOCK_BYTES) begin
				exp_state = lcg_next(exp_state);
				want      = exp_state[23:16];
			end else begin
				want = fill_byte(10'(i));
			end
			check_value($sformatf("buffer[%0d]", i), val, want);
		end
		finish_test("dma two blocks", errs);
	endtask

	task automatic track_sector_unmapped();
		int         errs;
		logic [7:0] val;
		errs = err_count;
		host_write(WD_TRACK, 8'h27);
		host_write(WD_SECTOR, 8'h09);
		wh_read(io_addr(PORT_TRACK), val);
		check_value("PORT_TRACK", val, 8'h27);
		wh_read(io_addr(PORT_SECTOR), val);
		check_value("PORT_SECTOR", val, 8'h09);
		host_read(WD_TRACK, val);
		check_value("host track", val, 8'h27);
		wh_read(io_addr(8'h30), val);
		check_value("unmapped port", val, 8'hFF);
		wh_read(16'h1000, val);
		check_value("unmapped address", val, 8'hFF);
		finish_test("track sector unmapped", errs);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial begin
		clk         = 1'b0;
		reset_n     = 1'b0;
		host_addr   = 3'd0;
		host_wdata  = 8'h00;
		host_rd     = 1'b0;
		host_wr     = 1'b0;
		wh_bus      = '0;
		check_count = 0;
		err_count   = 0;
		mosi_shift  = 8'h00;
		mosi_byte   = 8'h00;
		card_state  = 32'd75;
		exp_state   = 32'd75;
		card_load_next();
		repeat (16) @(posedge clk);
		#1;
		reset_n = 1'b1;

		reset_values();
		command_exchange();
		data_path();
		spi_port_byte();
		dma_two_blocks();
		track_sector_unmapped();

		$display("checks %0d, errors %0d", check_count, err_count);
		if (err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns, the tests did not complete", TIMEOUT_NS);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- floppy_emu.f
common/floppy_pkg.sv
logic/sector_buffer.sv
logic/io_port_regs.sv
logic/spi_master.sv
logic/sector_dma.sv
wd1793/wd_host_regs.sv
logic/floppy_emu.sv
sim/floppy_emu_props.sv
sim/floppy_emu_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the floppy_emu testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f floppy_emu.f --top-module floppy_emu_tb -o floppy_emu_sim &&
./obj_dir/floppy_emu_sim | tee /dev/stderr | grep -qx "test passed" &&
echo "floppy_emu: simulation ok" ||
{ echo "floppy_emu: simulation reported a failure"; exit 1; }
